/* motor_mixer_top.f */
+incdir+rtl
rtl/flight_pkg.sv
rtl/axi_lite_pkg.sv
rtl/mixer_cfg_regs.sv
rtl/motor_rate_calculator.sv
rtl/motor_output_stage.sv
rtl/motor_mixer_top.sv
test/tb_clock_gen.sv
test/motor_mixer_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the motor mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module motor_mixer_tb \
  -f motor_mixer_top.f \
  -o motor_mixer_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/motor_mixer_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
  exit 0
else
  exit 1
fi

/* test/motor_mixer_tb.sv */
//##########################################################
// stimulus, reference model, assertions and watchdog
// for the motor mixer
//##########################################################
`include "mixer_defs.svh"

module motor_mixer_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // tests take about 750 cycles and the watchdog four times that
  localparam int TEST_CYCLES     = 750;
  localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;
  localparam int STREAM_SAMPLES  = 200;
  localparam int STALL_CYCLES    = 6;
  // command for a rate of 0x4000 with no attitude input
  localparam int BASE_CMD        = 64;

  // X frame signs with index 0 as motor 1
  localparam int SIGN_YAW [4]   = '{-1, 1, 1, -1};
  localparam int SIGN_ROLL [4]  = '{1, -1, 1, -1};
  localparam int SIGN_PITCH [4] = '{-1, -1, 1, 1};

  logic                    sys_clk;
  logic                    rst_n;
  axi_lite_pkg::axil_req_t axil_req;
  axi_lite_pkg::axil_rsp_t axil_rsp;
  logic                    rate_valid;
  flight_pkg::rate_cmd_t   rate_cmd;
  logic                    esc_valid;
  flight_pkg::esc_cmd_t    esc_cmd;
  logic [3:0]              reject_flags;

  int    error_count = 0;
  int    seed        = 83;
  int    axi_stall   = 0;
  string test_name   = "reset_regs";

  // model copy of the registers tracked from bus writes
  logic [15:0] mdl_bias;
  logic [7:0]  mdl_esc_min;
  logic [7:0]  mdl_esc_max;
  int          mdl_rejects;
  int          mdl_held [4];
  int          mdl_mapped;
  logic [3:0]  mdl_flags;

  // expected motor outputs three stages deep
  logic [2:0]           exp_valid;
  flight_pkg::esc_cmd_t exp_cmd_d1;
  flight_pkg::esc_cmd_t exp_cmd_d2;
  flight_pkg::esc_cmd_t exp_cmd_d3;
  logic [3:0]           exp_flags_d1;
  logic [3:0]           exp_flags_d2;
  logic [3:0]           exp_flags_d3;

  // samples sent but not yet seen at the output
  int                   outstanding;
  flight_pkg::esc_cmd_t last_cmd;

  tb_clock_gen u_clock_gen (
    .sys_clk (sys_clk),
    .rst_n   (rst_n)
  );

  motor_mixer_top i_dut (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .axil_req     (axil_req),
    .axil_rsp     (axil_rsp),
    .rate_valid   (rate_valid),
    .rate_cmd     (rate_cmd),
    .esc_valid    (esc_valid),
    .esc_cmd      (esc_cmd),
    .reject_flags (reject_flags)
  );

  // division by two rounded toward minus infinity
  function automatic int floor_half(input int v);
    int h;
    h = v / 2;
    if ((v < 0) && (v % 2 != 0)) begin
      h = h - 1;
    end
    return h;
  endfunction

  // full path for one motor from mix through clamp to 8-bit rounding
  function automatic int mix_motor(input int m, input flight_pkg::rate_cmd_t c,
                                   input logic [15:0] bias);
    int throttle_v;
    int yaw_v;
    int roll_v;
    int pitch_v;
    int sum;
    int cmd;
    throttle_v = c.throttle;
    yaw_v      = c.yaw;
    roll_v     = c.roll;
    pitch_v    = c.pitch;
    sum = int'(bias) + throttle_v + SIGN_YAW[m] * floor_half(yaw_v) +
          SIGN_ROLL[m] * floor_half(roll_v) + SIGN_PITCH[m] * floor_half(pitch_v);
    if (sum < 0) begin
      sum = 0;
    end else if (sum > 65535) begin
      sum = 65535;
    end
    cmd = (sum + `MAP_ROUND) / 256;
    if (cmd > 255) begin
      cmd = 255;
    end
    return cmd;
  endfunction

  function automatic int cmd_field(input flight_pkg::esc_cmd_t c, input int m);
    case (m)
      0:       return int'(c.m1);
      1:       return int'(c.m2);
      2:       return int'(c.m3);
      default: return int'(c.m4);
    endcase
  endfunction

  // reference model on the same edges as the DUT
  always @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      mdl_bias    = `BIAS_RST;
      mdl_esc_min = `ESC_MIN_RST;
      mdl_esc_max = `ESC_MAX_RST;
      mdl_rejects = 0;
      for (int m = 0; m < 4; m++) begin
        mdl_held[m] = 0;
      end
      exp_valid   <= '0;
      outstanding <= 0;
    end else begin
      // register writes as the host issues them
      if (axil_req.awvalid && axil_req.wvalid && axil_rsp.awready) begin
        case (axil_req.awaddr)
          `REG_BIAS: begin
            if (axil_req.wstrb[0]) mdl_bias[7:0] = axil_req.wdata[7:0];
            if (axil_req.wstrb[1]) mdl_bias[15:8] = axil_req.wdata[15:8];
          end
          `REG_ESC_MIN: if (axil_req.wstrb[0]) mdl_esc_min = axil_req.wdata[7:0];
          `REG_ESC_MAX: if (axil_req.wstrb[0]) mdl_esc_max = axil_req.wdata[7:0];
          `REG_REJECTS: mdl_rejects = 0;
          default: ;
        endcase
      end
      mdl_flags = '0;
      if (rate_valid) begin
        for (int m = 0; m < 4; m++) begin
          mdl_mapped = mix_motor(m, rate_cmd, mdl_bias);
          // inside the window it becomes the new held command
          if ((mdl_mapped >= mdl_esc_min) && (mdl_mapped <= mdl_esc_max)) begin
            mdl_held[m] = mdl_mapped;
          end else begin
            mdl_flags[m] = 1'b1;
            if (mdl_rejects < 65535) mdl_rejects++;
          end
        end
      end
      exp_valid    <= {exp_valid[1:0], rate_valid};
      exp_cmd_d1   <= '{m1: 8'(mdl_held[0]), m2: 8'(mdl_held[1]),
                        m3: 8'(mdl_held[2]), m4: 8'(mdl_held[3])};
      exp_cmd_d2   <= exp_cmd_d1;
      exp_cmd_d3   <= exp_cmd_d2;
      exp_flags_d1 <= mdl_flags;
      exp_flags_d2 <= exp_flags_d1;
      exp_flags_d3 <= exp_flags_d2;
      outstanding  <= outstanding + int'(rate_valid) - int'(esc_valid);
      if (esc_valid) last_cmd <= esc_cmd;
    end
  end

  // esc_valid exactly three edges after rate_valid
  a_esc_timing: assert property (@(posedge sys_clk) disable iff (!rst_n)
    esc_valid == exp_valid[2])
  else begin
    error_count++;
    $display("CHECK FAILED %s esc_valid expected %b actual %b", test_name,
             $sampled(exp_valid[2]), $sampled(esc_valid));
  end

  a_esc_cmd: assert property (@(posedge sys_clk) disable iff (!rst_n)
    esc_valid |-> esc_cmd == exp_cmd_d3)
  else begin
    error_count++;
    $display("CHECK FAILED %s esc_cmd expected %h actual %h", test_name,
             $sampled(exp_cmd_d3), $sampled(esc_cmd));
  end

  a_reject_flags: assert property (@(posedge sys_clk) disable iff (!rst_n)
    esc_valid |-> reject_flags == exp_flags_d3)
  else begin
    error_count++;
    $display("CHECK FAILED %s reject_flags expected %b actual %b", test_name,
             $sampled(exp_flags_d3), $sampled(reject_flags));
  end

  // stalled responses must hold
  a_b_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
  else begin
    error_count++;
    $display("%s: write response dropped or changed while bready was low", test_name);
  end

  a_r_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
  else begin
    error_count++;
    $display("%s: read data dropped or changed while rready was low", test_name);
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual)
    else begin
      error_count++;
      $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    @(posedge sys_clk);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= strb;
    axil_req.wvalid  <= 1'b1;
    // address and data go in together
    do @(posedge sys_clk); while (!axil_rsp.awready);
    // wready pulses in the same cycle as awready
    check_value("wready", 32'd1, 32'(axil_rsp.wready));
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    do @(posedge sys_clk); while (!axil_rsp.bvalid);
    repeat (axi_stall) @(posedge sys_clk);
    axil_req.bready <= 1'b1;
    @(posedge sys_clk);
    resp = axil_rsp.bresp;
    axil_req.bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge sys_clk);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    do @(posedge sys_clk); while (!axil_rsp.arready);
    axil_req.arvalid <= 1'b0;
    do @(posedge sys_clk); while (!axil_rsp.rvalid);
    repeat (axi_stall) @(posedge sys_clk);
    axil_req.rready <= 1'b1;
    @(posedge sys_clk);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    axil_req.rready <= 1'b0;
  endtask

  task automatic write_check(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] exp_resp);
    logic [1:0] resp;
    axi_write(addr, data, strb, resp);
    check_value("bresp", 32'(exp_resp), 32'(resp));
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    check_value("rdata", exp_data, data);
    check_value("rresp", 32'(exp_resp), 32'(resp));
  endtask

  task automatic send_sample(input int throttle, input int yaw, input int roll,
                             input int pitch);
    @(posedge sys_clk);
    rate_valid        <= 1'b1;
    rate_cmd.throttle <= 16'(throttle);
    rate_cmd.yaw      <= 16'(yaw);
    rate_cmd.roll     <= 16'(roll);
    rate_cmd.pitch    <= 16'(pitch);
  endtask

  task automatic send_random();
    send_sample($random(seed), $random(seed), $random(seed), $random(seed));
  endtask

  // stop sending and wait until every sample has come out
  task automatic end_samples();
    @(posedge sys_clk);
    rate_valid <= 1'b0;
    do @(posedge sys_clk); while (outstanding != 0);
  endtask

  // axis 0 is yaw, 1 roll and 2 pitch while dir gives the step sign
  task automatic check_direction(input int axis, input int dir);
    int sign;
    int act;
    for (int m = 0; m < 4; m++) begin
      case (axis)
        0:       sign = SIGN_YAW[m];
        1:       sign = SIGN_ROLL[m];
        default: sign = SIGN_PITCH[m];
      endcase
      act = cmd_field(last_cmd, m);
      assert ((sign * dir > 0) ? (act > BASE_CMD) : (act < BASE_CMD))
      else begin
        error_count++;
        $display("CHECK FAILED %s motor %0d expected %s %0d actual %0d", test_name, m + 1,
                 (sign * dir > 0) ? "above" : "below", BASE_CMD, act);
      end
    end
  endtask

  initial begin
    axil_req   = '0;
    rate_valid = 1'b0;
    rate_cmd   = '0;
    do @(posedge sys_clk); while (!rst_n);

    // reset values, byte strobes and the unmapped address
    test_name = "reset_regs";
    read_check(`REG_BIAS, 32'd0, axi_lite_pkg::OKAY);
    read_check(`REG_ESC_MIN, 32'd16, axi_lite_pkg::OKAY);
    read_check(`REG_ESC_MAX, 32'd240, axi_lite_pkg::OKAY);
    read_check(`REG_REJECTS, 32'd0, axi_lite_pkg::OKAY);
    write_check(`REG_BIAS, 32'h0000_1234, 4'b1111, axi_lite_pkg::OKAY);
    write_check(`REG_BIAS, 32'h0000_ABCD, 4'b0010, axi_lite_pkg::OKAY);
    read_check(`REG_BIAS, 32'h0000_AB34, axi_lite_pkg::OKAY);
    write_check(`REG_ESC_MIN, 32'h0000_0055, 4'b1110, axi_lite_pkg::OKAY);
    read_check(`REG_ESC_MIN, 32'd16, axi_lite_pkg::OKAY);
    read_check(8'h10, 32'd0, axi_lite_pkg::SLVERR);
    write_check(8'h10, 32'hFFFF_FFFF, 4'b1111, axi_lite_pkg::SLVERR);

    // one axis at a time in both directions
    test_name = "mixing_signs";
    write_check(`REG_BIAS, 32'h0000_4000, 4'b0011, axi_lite_pkg::OKAY);
    for (int axis = 0; axis < 3; axis++) begin
      for (int dir = -1; dir <= 1; dir += 2) begin
        send_sample(0, (axis == 0) ? dir * 'h2000 : 0, (axis == 1) ? dir * 'h2000 : 0,
                    (axis == 2) ? dir * 'h2000 : 0);
        end_samples();
        check_direction(axis, dir);
      end
    end

    // clamp high, clamp low into hold and rounding around half an LSB
    test_name = "clamp_map";
    write_check(`REG_ESC_MAX, 32'd255, 4'b0001, axi_lite_pkg::OKAY);
    write_check(`REG_BIAS, 32'h0000_FFFF, 4'b0011, axi_lite_pkg::OKAY);
    send_sample('h7FFF, 0, 0, 0);
    end_samples();
    check_value("esc_cmd", 32'hFFFF_FFFF, last_cmd);
    write_check(`REG_BIAS, 32'h0000_0000, 4'b0011, axi_lite_pkg::OKAY);
    send_sample(-32768, 0, 0, 0);
    end_samples();
    check_value("esc_cmd", 32'hFFFF_FFFF, last_cmd);
    write_check(`REG_BIAS, 32'h0000_127F, 4'b0011, axi_lite_pkg::OKAY);
    send_sample(0, 0, 0, 0);
    end_samples();
    check_value("esc_cmd", 32'h1212_1212, last_cmd);
    write_check(`REG_BIAS, 32'h0000_1280, 4'b0011, axi_lite_pkg::OKAY);
    send_sample(0, 0, 0, 0);
    end_samples();
    check_value("esc_cmd", 32'h1313_1313, last_cmd);

    // narrow window with hold and reject count
    test_name = "window_hold";
    write_check(`REG_ESC_MIN, 32'h0000_0040, 4'b0001, axi_lite_pkg::OKAY);
    write_check(`REG_ESC_MAX, 32'h0000_0080, 4'b0001, axi_lite_pkg::OKAY);
    write_check(`REG_BIAS, 32'h0000_6000, 4'b0011, axi_lite_pkg::OKAY);
    write_check(`REG_REJECTS, 32'h0, 4'b1111, axi_lite_pkg::OKAY);
    send_sample(0, 0, 0, 0);
    send_sample(0, 'h1000, 'h6000, 0);
    send_sample(0, 0, 0, 'h4000);
    send_sample('h1000, 'h2000, 0, 0);
    send_sample('h2000, 0, 0, 'h2000);
    end_samples();
    read_check(`REG_REJECTS, 32'(mdl_rejects), axi_lite_pkg::OKAY);
    write_check(`REG_REJECTS, 32'h0, 4'b1111, axi_lite_pkg::OKAY);
    read_check(`REG_REJECTS, 32'd0, axi_lite_pkg::OKAY);

    // random samples on every cycle
    test_name = "streaming";
    write_check(`REG_ESC_MIN, 32'd16, 4'b0001, axi_lite_pkg::OKAY);
    write_check(`REG_ESC_MAX, 32'd240, 4'b0001, axi_lite_pkg::OKAY);
    write_check(`REG_BIAS, 32'h0000_8000, 4'b0011, axi_lite_pkg::OKAY);
    for (int i = 0; i < STREAM_SAMPLES; i++) begin
      send_random();
    end
    end_samples();
    read_check(`REG_REJECTS, 32'(mdl_rejects), axi_lite_pkg::OKAY);

    // stalled responses while the motor path keeps running
    test_name = "axi_backpressure";
    axi_stall = STALL_CYCLES;
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          send_random();
        end
        end_samples();
      end
      begin
        // same bias again so the stream sees no change
        write_check(`REG_BIAS, 32'(mdl_bias), 4'b0011, axi_lite_pkg::OKAY);
        read_check(`REG_ESC_MAX, 32'(mdl_esc_max), axi_lite_pkg::OKAY);
      end
    join
    axi_stall = 0;

    $display("tests done, errors: %0d", error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
    $display("timeout: run did not finish within %0d cycles, errors: %0d",
             WATCHDOG_CYCLES, error_count);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* test/tb_clock_gen.sv */
//##########################################################
// testbench clock, 20 ns period, reset low for 10 cycles
//##########################################################
module tb_clock_gen #(
  parameter int RESET_CYCLES = 10
) (
  output logic sys_clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // half of the 20 ns period
  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
  end

  // release on a rising edge, like any other stimulus
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    rst_n <= 1'b1;
  end

endmodule

/* rtl/motor_mixer_top.sv */
//##########################################################
// motor mixer top: registers, four calculators, output
//##########################################################
`include "mixer_defs.svh"

module motor_mixer_top (
  input  logic                    sys_clk,
  input  logic                    rst_n,
  input  axi_lite_pkg::axil_req_t axil_req,
  output axi_lite_pkg::axil_rsp_t axil_rsp,
  input  logic                    rate_valid,
  input  flight_pkg::rate_cmd_t   rate_cmd,
  output logic                    esc_valid,
  output flight_pkg::esc_cmd_t    esc_cmd,
  output logic [3:0]              reject_flags
);

  flight_pkg::mixer_cfg_t   cfg;
  flight_pkg::motor_rates_t rates;
  logic [2:0]               reject_count_inc;

  // lockstep, only motor 1 valid is used
  logic                     rates_valid;
  logic [`RATE_W-1:0]       m1_rate;
  logic [`RATE_W-1:0]       m2_rate;
  logic [`RATE_W-1:0]       m3_rate;
  logic [`RATE_W-1:0]       m4_rate;

  mixer_cfg_regs u_cfg_regs (
    .sys_clk          (sys_clk),
    .rst_n            (rst_n),
    .axil_req         (axil_req),
    .axil_rsp         (axil_rsp),
    .cfg              (cfg),
    .reject_count_inc (reject_count_inc)
  );

  // front left, -yaw +roll -pitch
  motor_rate_calculator #(.YAW_NEG(1'b1), .ROLL_NEG(1'b0), .PITCH_NEG(1'b1)) u_calc_m1 (
    .sys_clk        (sys_clk),
    .rst_n          (rst_n),
    .rate_valid     (rate_valid),
    .rate_cmd       (rate_cmd),
    .bias           (cfg.bias),
    .rate_out_valid (rates_valid),
    .motor_rate     (m1_rate)
  );

  // front right, +yaw -roll -pitch
  motor_rate_calculator #(.YAW_NEG(1'b0), .ROLL_NEG(1'b1), .PITCH_NEG(1'b1)) u_calc_m2 (
    .sys_clk        (sys_clk),
    .rst_n          (rst_n),
    .rate_valid     (rate_valid),
    .rate_cmd       (rate_cmd),
    .bias           (cfg.bias),
    .rate_out_valid (),
    .motor_rate     (m2_rate)
  );

  // rear left, all positive
  motor_rate_calculator #(.YAW_NEG(1'b0), .ROLL_NEG(1'b0), .PITCH_NEG(1'b0)) u_calc_m3 (
    .sys_clk        (sys_clk),
    .rst_n          (rst_n),
    .rate_valid     (rate_valid),
    .rate_cmd       (rate_cmd),
    .bias           (cfg.bias),
    .rate_out_valid (),
    .motor_rate     (m3_rate)
  );

  // rear right, -yaw -roll +pitch
  motor_rate_calculator #(.YAW_NEG(1'b1), .ROLL_NEG(1'b1), .PITCH_NEG(1'b0)) u_calc_m4 (
    .sys_clk        (sys_clk),
    .rst_n          (rst_n),
    .rate_valid     (rate_valid),
    .rate_cmd       (rate_cmd),
    .bias           (cfg.bias),
    .rate_out_valid (),
    .motor_rate     (m4_rate)
  );

  assign rates = '{m1: m1_rate, m2: m2_rate, m3: m3_rate, m4: m4_rate};

  motor_output_stage u_output_stage (
    .sys_clk          (sys_clk),
    .rst_n            (rst_n),
    .rates_valid      (rates_valid),
    .rates            (rates),
    .esc_min          (cfg.esc_min),
    .esc_max          (cfg.esc_max),
    .esc_valid        (esc_valid),
    .esc_cmd          (esc_cmd),
    .reject_flags     (reject_flags),
    .reject_count_inc (reject_count_inc)
  );

endmodule

/* rtl/motor_output_stage.sv */
//##########################################################
// 16-to-8 mapping, ESC window with hold, reject reporting
//##########################################################
`include "mixer_defs.svh"

module motor_output_stage (
  input  logic                     sys_clk,
  input  logic                     rst_n,
  input  logic                     rates_valid,
  input  flight_pkg::motor_rates_t rates,
  input  logic [`ESC_W-1:0]        esc_min,
  input  logic [`ESC_W-1:0]        esc_max,
  output logic                     esc_valid,
  output flight_pkg::esc_cmd_t     esc_cmd,
  output logic [3:0]               reject_flags,
  output logic [2:0]               reject_count_inc
);

  // index 0 is motor 1
  logic [3:0][`RATE_W-1:0] rate_arr;
  logic [3:0][`RATE_W:0]   rounded;
  logic [3:0][`ESC_W-1:0]  mapped;
  logic [3:0]              in_window;
  logic [2:0]              reject_cnt;

  // last accepted command per motor
  logic [3:0][`ESC_W-1:0]  held_q;

  assign rate_arr = {rates.m4, rates.m3, rates.m2, rates.m1};

  always_comb begin
    reject_cnt = '0;
    for (int i = 0; i < 4; i++) begin
      // round, keep the top bits plus carry
      rounded[i] = {1'b0, rate_arr[i]} + (`RATE_W+1)'(`MAP_ROUND);
      // carry out means 256, saturate
      if (rounded[i][`RATE_W]) begin
        mapped[i] = '1;
      end else begin
        mapped[i] = rounded[i][`RATE_W-1:`RATE_W-`ESC_W];
      end
      // inclusive window
      in_window[i] = (mapped[i] >= esc_min) && (mapped[i] <= esc_max);
      reject_cnt   = reject_cnt + 3'(!in_window[i]);
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      esc_valid        <= 1'b0;
      held_q           <= '0;
      reject_flags     <= '0;
      reject_count_inc <= '0;
    end else begin
      esc_valid <= rates_valid;
      if (rates_valid) begin
        for (int i = 0; i < 4; i++) begin
          // rejected motors keep the old value
          if (in_window[i]) begin
            held_q[i] <= mapped[i];
          end
        end
        reject_flags     <= ~in_window;
        reject_count_inc <= reject_cnt;
      end else begin
        // flags only mark a live sample
        reject_flags     <= '0;
        reject_count_inc <= '0;
      end
    end
  end

  // command is always the held value, new or replayed
  assign esc_cmd = '{m1: held_q[0], m2: held_q[1], m3: held_q[2], m4: held_q[3]};

endmodule

/* rtl/motor_rate_calculator.sv */
//##########################################################
// two-stage signed mixing pipeline for one motor
//##########################################################
`include "mixer_defs.svh"

module motor_rate_calculator #(
  // sign pattern of the frame position, 1 subtracts the term
  parameter bit YAW_NEG   = 1'b0,
  parameter bit ROLL_NEG  = 1'b0,
  parameter bit PITCH_NEG = 1'b0
) (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  logic                  rate_valid,
  input  flight_pkg::rate_cmd_t rate_cmd,
  input  logic [`RATE_W-1:0]    bias,
  output logic                  rate_out_valid,
  output logic [`RATE_W-1:0]    motor_rate
);

  // halve with floor, then apply the sign
  function automatic logic signed [`RATE_W-1:0] attitude_term(
    input logic signed [`RATE_W-1:0] rate,
    input bit                        neg
  );
    logic signed [`RATE_W-1:0] half;
    half = rate >>> 1;
    return neg ? -half : half;
  endfunction

  logic                      valid_s1;
  logic signed [`RATE_W-1:0] throttle_s1;
  logic signed [`RATE_W-1:0] yaw_s1;
  logic signed [`RATE_W-1:0] roll_s1;
  logic signed [`RATE_W-1:0] pitch_s1;

  logic signed [`SUM_W-1:0] bias_ext;
  logic signed [`SUM_W-1:0] sum;
  logic [`RATE_W-1:0]       sum_clamped;

  // stage 1 valid
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= rate_valid;
    end
  end

  // stage 1 terms, loaded per sample
  always_ff @(posedge sys_clk) begin
    if (rate_valid) begin
      throttle_s1 <= rate_cmd.throttle;
      yaw_s1      <= attitude_term(rate_cmd.yaw, YAW_NEG);
      roll_s1     <= attitude_term(rate_cmd.roll, ROLL_NEG);
      pitch_s1    <= attitude_term(rate_cmd.pitch, PITCH_NEG);
    end
  end

  // bias is unsigned, zero extend
  assign bias_ext = {{(`SUM_W - `RATE_W){1'b0}}, bias};

  // all operands signed, so terms sign extend
  assign sum = bias_ext + throttle_s1 + yaw_s1 + roll_s1 + pitch_s1;

  // clamp to 0..65535
  always_comb begin
    if (sum[`SUM_W-1]) begin
      sum_clamped = '0;
    end else if (|sum[`SUM_W-2:`RATE_W]) begin
      sum_clamped = '1;
    end else begin
      sum_clamped = sum[`RATE_W-1:0];
    end
  end

  // stage 2
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rate_out_valid <= 1'b0;
    end else begin
      rate_out_valid <= valid_s1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (valid_s1) begin
      motor_rate <= sum_clamped;
    end
  end

endmodule

/* rtl/mixer_cfg_regs.sv */
//##########################################################
// AXI4-Lite slave with bias, ESC window and reject counter
//##########################################################
`include "mixer_defs.svh"

module mixer_cfg_regs (
  input  logic                    sys_clk,
  input  logic                    rst_n,
  input  axi_lite_pkg::axil_req_t axil_req,
  output axi_lite_pkg::axil_rsp_t axil_rsp,
  output flight_pkg::mixer_cfg_t  cfg,
  input  logic [2:0]              reject_count_inc
);

  axi_lite_pkg::axil_wr_state_e wr_state;
  axi_lite_pkg::axil_rd_state_e rd_state;
  axi_lite_pkg::axil_resp_e     bresp_q;
  axi_lite_pkg::axil_resp_e     rresp_q;
  logic [31:0]                  rdata_q;

  flight_pkg::mixer_cfg_t cfg_q;
  logic [15:0]            reject_count;
  logic [16:0]            reject_sum;

  logic        aw_fire;
  logic        ar_fire;
  logic        wr_hit;
  logic        rd_hit;
  logic        rej_clr;
  logic [31:0] rd_mux;

  // accept address and data only together, one at a time
  assign aw_fire = (wr_state == axi_lite_pkg::WR_IDLE) &&
                   axil_req.awvalid && axil_req.wvalid;
  assign ar_fire = (rd_state == axi_lite_pkg::RD_IDLE) && axil_req.arvalid;

  // address decode
  assign wr_hit = (axil_req.awaddr == `REG_BIAS)    ||
                  (axil_req.awaddr == `REG_ESC_MIN) ||
                  (axil_req.awaddr == `REG_ESC_MAX) ||
                  (axil_req.awaddr == `REG_REJECTS);
  assign rej_clr = aw_fire && (axil_req.awaddr == `REG_REJECTS);

  always_comb begin
    rd_hit = 1'b1;
    rd_mux = '0;
    case (axil_req.araddr)
      `REG_BIAS:    rd_mux = 32'(cfg_q.bias);
      `REG_ESC_MIN: rd_mux = 32'(cfg_q.esc_min);
      `REG_ESC_MAX: rd_mux = 32'(cfg_q.esc_max);
      `REG_REJECTS: rd_mux = 32'(reject_count);
      // unmapped, zero data
      default:      rd_hit = 1'b0;
    endcase
  end

  // write channel FSM
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_state <= axi_lite_pkg::WR_IDLE;
    end else begin
      case (wr_state)
        axi_lite_pkg::WR_IDLE: if (aw_fire) wr_state <= axi_lite_pkg::WR_RESP;
        axi_lite_pkg::WR_RESP: if (axil_req.bready) wr_state <= axi_lite_pkg::WR_IDLE;
        default:               wr_state <= axi_lite_pkg::WR_IDLE;
      endcase
    end
  end

  // read channel FSM
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_state <= axi_lite_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        axi_lite_pkg::RD_IDLE: if (ar_fire) rd_state <= axi_lite_pkg::RD_DATA;
        axi_lite_pkg::RD_DATA: if (axil_req.rready) rd_state <= axi_lite_pkg::RD_IDLE;
        default:               rd_state <= axi_lite_pkg::RD_IDLE;
      endcase
    end
  end

  // response payload, held while the channel waits
  always_ff @(posedge sys_clk) begin
    if (aw_fire) begin
      bresp_q <= wr_hit ? axi_lite_pkg::OKAY : axi_lite_pkg::SLVERR;
    end
    if (ar_fire) begin
      rdata_q <= rd_mux;
      rresp_q <= rd_hit ? axi_lite_pkg::OKAY : axi_lite_pkg::SLVERR;
    end
  end

  // config registers, byte strobes honoured
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q.bias    <= `BIAS_RST;
      cfg_q.esc_min <= `ESC_MIN_RST;
      cfg_q.esc_max <= `ESC_MAX_RST;
    end else if (aw_fire) begin
      case (axil_req.awaddr)
        `REG_BIAS: begin
          if (axil_req.wstrb[0]) cfg_q.bias[7:0]  <= axil_req.wdata[7:0];
          if (axil_req.wstrb[1]) cfg_q.bias[15:8] <= axil_req.wdata[15:8];
        end
        `REG_ESC_MIN: if (axil_req.wstrb[0]) cfg_q.esc_min <= axil_req.wdata[7:0];
        `REG_ESC_MAX: if (axil_req.wstrb[0]) cfg_q.esc_max <= axil_req.wdata[7:0];
        default: ;
      endcase
    end
  end

  // saturating reject counter, clear wins over increment
  assign reject_sum = {1'b0, reject_count} + 17'(reject_count_inc);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      reject_count <= '0;
    end else if (rej_clr) begin
      reject_count <= '0;
    end else if (reject_sum[16]) begin
      reject_count <= 16'hFFFF;
    end else begin
      reject_count <= reject_sum[15:0];
    end
  end

  assign cfg = cfg_q;

  always_comb begin
    axil_rsp.awready = aw_fire;
    axil_rsp.wready  = aw_fire;
    axil_rsp.bvalid  = (wr_state == axi_lite_pkg::WR_RESP);
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = ar_fire;
    axil_rsp.rvalid  = (rd_state == axi_lite_pkg::RD_DATA);
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

endmodule

/* rtl/axi_lite_pkg.sv */
//##########################################################
// AXI4-Lite request/response structs, response codes
// and channel state enums
//##########################################################
package axi_lite_pkg;

  // master to slave
  typedef struct packed {
    logic [7:0]  awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  // write channel, address and data taken together
  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } axil_wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } axil_rd_state_e;

endpackage

/* rtl/flight_pkg.sv */
//##########################################################
// flight-side types: rate command, motor rates, ESC
// commands and mixer configuration
//##########################################################
`include "mixer_defs.svh"

package flight_pkg;

  // one PID output sample, signed fixed point
  typedef struct packed {
    logic signed [`RATE_W-1:0] throttle;
    logic signed [`RATE_W-1:0] yaw;
    logic signed [`RATE_W-1:0] roll;
    logic signed [`RATE_W-1:0] pitch;
  } rate_cmd_t;

  // clamped calculator results, one per motor
  typedef struct packed {
    logic [`RATE_W-1:0] m1;
    logic [`RATE_W-1:0] m2;
    logic [`RATE_W-1:0] m3;
    logic [`RATE_W-1:0] m4;
  } motor_rates_t;

  // commands as sent to the ESCs
  typedef struct packed {
    logic [`ESC_W-1:0] m1;
    logic [`ESC_W-1:0] m2;
    logic [`ESC_W-1:0] m3;
    logic [`ESC_W-1:0] m4;
  } esc_cmd_t;

  // host programmable values
  typedef struct packed {
    // added to every motor before clamping
    logic [`RATE_W-1:0] bias;
    // inclusive ESC window
    logic [`ESC_W-1:0]  esc_min;
    logic [`ESC_W-1:0]  esc_max;
  } mixer_cfg_t;

endpackage

/* rtl/mixer_defs.svh */
//##########################################################
// widths, register offsets and configuration reset values
// shared by the motor mixer
//##########################################################
`ifndef MIXER_DEFS_SVH
`define MIXER_DEFS_SVH

// signed rate inputs and unsigned motor rate
`define RATE_W 16
// one ESC command
`define ESC_W 8
// internal mixing sum, bias plus four terms without overflow
`define SUM_W 19

// host register byte offsets
`define REG_BIAS    8'h00
`define REG_ESC_MIN 8'h04
`define REG_ESC_MAX 8'h08
`define REG_REJECTS 8'h0C

// configuration values after reset
`define BIAS_RST    16'd0
`define ESC_MIN_RST 8'd16
`define ESC_MAX_RST 8'd240

// half an LSB of the 8-bit command, for rounding
`define MAP_ROUND 128

`endif
